// File: dv/regAddrPathVectors.txt
// code rn rd rs rm rdLo ctrl mode stall | ra1 ra2 wa3W flags   (hex, indices physical, ff none)
// ctrl: 0 mult 1 pc 2 store 3 shift 4 imm 5 multLo; stall: 0 sE 1 sM 2 fM 3 sW 4 fW
01 d 2 0 e 0 00 10 00  0d 0e ff 00
01 d 3 0 e 0 00 11 00  15 16 ff 00
01 d 4 0 f 0 00 12 00  17 0f ff 00
01 d 5 0 e 0 00 13 00  19 1a 02 00
01 f 6 0 e 0 00 1b 00  0f 1e 03 00
02 1 8 0 7 0 02 10 00  0f 07 04 00
02 9 a 0 b 0 04 10 00  09 0a 05 00
02 c 0 1 3 0 01 10 00  03 01 06 00
02 0 7 b 1 0 08 10 00  0b 01 08 00
03 0 2 0 0 0 00 10 00  00 00 0a 00
03 0 3 0 0 0 00 10 04  00 00 0c 00
03 0 4 0 0 0 00 10 00  00 00 07 00
03 0 5 0 0 0 00 10 10  00 00 ff 00
03 4 6 0 0 0 00 10 00  04 00 ff 00
04 1 7 0 0 0 00 10 0b  01 00 04 02
04 1 7 0 0 0 00 10 0b  01 00 04 02
04 1 7 0 0 0 00 10 00  01 00 04 02
04 0 8 0 0 0 00 10 00  00 00 05 00
05 0 9 0 0 0 00 10 00  00 00 06 00
05 9 a 0 0 0 00 10 00  09 00 07 10
05 9 b 0 0 0 00 10 00  09 00 08 01
05 0 c 0 b 0 10 10 00  00 0b 09 02
05 0 1 0 0 0 00 10 00  00 00 0a 00
06 2 d 4 5 0 01 13 00  05 04 0b 00
06 d 6 0 0 d 20 13 00  19 00 0c 00
06 0 7 0 0 0 00 10 00  00 00 01 01
06 0 8 0 0 0 00 10 00  00 00 19 00
06 0 8 0 0 0 00 10 00  00 00 06 00

// File: sources.f
verilog/regBankPkg.sv
verilog/instrFieldPkg.sv
verilog/regAddrIf.sv
verilog/srcAddrDecode.sv
verilog/destAddrPipe.sv
verilog/hazardMatch.sv
verilog/regAddrPath.sv
dv/regAddrPathChecker.sv
dv/regAddrPathTb.sv

// File: run.sh
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

verilator --binary -f sources.f --top-module regAddrPathTb -o regAddrPathSim

simOut=$(./obj_dir/regAddrPathSim)
echo "$simOut"

if grep -qx "Finished with no errors" <<< "$simOut"; then
  exit 0
else
  exit 1
fi

// File: dv/regAddrPathTb.sv
`timescale 1ns/1ps

module regAddrPathTb
  import regBankPkg::*;
  import instrFieldPkg::*;
();

  // ======================================================================
  // Run geometry
  // ======================================================================

  localparam int NumVectors  = 28;
  localparam int NumCols     = 13;
  localparam int ResetCycles = 4;
  localparam int ClkPeriod   = 20;
  // Twice the nominal run length
  localparam int WatchdogNs  = (NumVectors + ResetCycles) * ClkPeriod * 2;

  // Column positions in a vector line
  localparam int ColCode  = 0;
  localparam int ColRn    = 1;
  localparam int ColRd    = 2;
  localparam int ColRs    = 3;
  localparam int ColRm    = 4;
  localparam int ColRdLo  = 5;
  localparam int ColCtrl  = 6;
  localparam int ColMode  = 7;
  localparam int ColStall = 8;
  localparam int ColRa1   = 9;
  localparam int ColRa2   = 10;
  localparam int ColWa3W  = 11;
  localparam int ColFlags = 12;

  logic [7:0] vecMem [0:NumVectors*NumCols-1];

  // DUT inputs
  logic                  clk;
  logic                  arstN;
  logic [InstrWidth-1:0] instrD;
  logic [InstrWidth-1:0] instrE;
  logic                  multSelectD;
  logic [RegSrcBits-1:0] regSrcD;
  logic                  regShiftD;
  logic                  aluSrcD;
  logic                  writeMultLoE;
  procModeT              modeD;
  logic                  stallE;
  logic                  stallM;
  logic                  flushM;
  logic                  stallW;
  logic                  flushW;

  // DUT outputs
  oneHotAddrT ra1D;
  oneHotAddrT ra2D;
  oneHotAddrT wa3W;
  logic       match1EM;
  logic       match1EW;
  logic       match2EM;
  logic       match2EW;
  logic       match1DE;
  logic       match2DE;

  // Expected side handed to the checker
  logic       checkValid;
  int         vecIdx;
  logic [7:0] expCode;
  logic [7:0] expRa1Idx;
  logic [7:0] expRa2Idx;
  logic [7:0] expWa3WIdx;
  logic [7:0] expFlags;

  int mismatchCount;
  int otherCount;

  logic [31:0] randState;

  regAddrPath dut0 (
    .clk          (clk),
    .arstN        (arstN),
    .instrD       (instrD),
    .instrE       (instrE),
    .multSelectD  (multSelectD),
    .regSrcD      (regSrcD),
    .regShiftD    (regShiftD),
    .aluSrcD      (aluSrcD),
    .writeMultLoE (writeMultLoE),
    .modeD        (modeD),
    .stallE       (stallE),
    .stallM       (stallM),
    .flushM       (flushM),
    .stallW       (stallW),
    .flushW       (flushW),
    .ra1D         (ra1D),
    .ra2D         (ra2D),
    .wa3W         (wa3W),
    .match1EM     (match1EM),
    .match1EW     (match1EW),
    .match2EM     (match2EM),
    .match2EW     (match2EW),
    .match1DE     (match1DE),
    .match2DE     (match2DE)
  );

  regAddrPathChecker #(.NumVectors(NumVectors)) checker0 (
    .clk           (clk),
    .checkValid    (checkValid),
    .vecIdx        (vecIdx),
    .expCode       (expCode),
    .expRa1Idx     (expRa1Idx),
    .expRa2Idx     (expRa2Idx),
    .expWa3WIdx    (expWa3WIdx),
    .expFlags      (expFlags),
    .ra1D          (ra1D),
    .ra2D          (ra2D),
    .wa3W          (wa3W),
    .flags         ({match2DE, match1DE, match2EW, match2EM, match1EW, match1EM}),
    .mismatchCount (mismatchCount),
    .otherCount    (otherCount)
  );

  // ======================================================================
  // Clock and watchdog
  // ======================================================================

  initial begin
    clk = 1'b0;
    forever #(ClkPeriod / 2) clk = ~clk;
  end

  initial begin
    #(WatchdogNs);
    $display("Timeout: simulation did not finish within %0d ns", WatchdogNs);
    $display("Finished with errors");
    $finish;
  end

  // ======================================================================
  // Stimulus
  // ======================================================================

  // Numerical Recipes constants
  function automatic logic [31:0] lcgNext(input logic [31:0] state);
    return state * 32'd1664525 + 32'd1013904223;
  endfunction

  // One vector onto the DUT and the checker
  task automatic driveVector(input int i);
    int         base;
    logic [7:0] ctrl;
    logic [7:0] stall;
    base  = i * NumCols;
    ctrl  = vecMem[base + ColCtrl];
    stall = vecMem[base + ColStall];
    // Unread bits get noise
    randState = lcgNext(randState);
    instrD <= {randState[31:20], vecMem[base + ColRn][3:0], vecMem[base + ColRd][3:0],
               vecMem[base + ColRs][3:0], randState[7:4], vecMem[base + ColRm][3:0]};
    randState = lcgNext(randState);
    instrE <= {randState[31:16], vecMem[base + ColRdLo][3:0], randState[11:0]};
    multSelectD  <= ctrl[0];
    regSrcD      <= ctrl[2:1];
    regShiftD    <= ctrl[3];
    aluSrcD      <= ctrl[4];
    writeMultLoE <= ctrl[5];
    modeD        <= procModeT'(vecMem[base + ColMode][4:0]);
    stallE <= stall[0];
    stallM <= stall[1];
    flushM <= stall[2];
    stallW <= stall[3];
    flushW <= stall[4];
    // Expected side
    checkValid <= 1'b1;
    vecIdx     <= i;
    expCode    <= vecMem[base + ColCode];
    expRa1Idx  <= vecMem[base + ColRa1];
    expRa2Idx  <= vecMem[base + ColRa2];
    expWa3WIdx <= vecMem[base + ColWa3W];
    expFlags   <= vecMem[base + ColFlags];
  endtask

  initial begin
    randState    = 32'h35f7;
    arstN        = 1'b0;
    instrD       = '0;
    instrE       = '0;
    multSelectD  = 1'b0;
    regSrcD      = '0;
    regShiftD    = 1'b0;
    aluSrcD      = 1'b0;
    writeMultLoE = 1'b0;
    modeD        = ModeUser;
    stallE       = 1'b0;
    stallM       = 1'b0;
    flushM       = 1'b0;
    stallW       = 1'b0;
    flushW       = 1'b0;
    checkValid   = 1'b0;
    vecIdx       = 0;
    expCode      = '0;
    expRa1Idx    = '0;
    expRa2Idx    = '0;
    expWa3WIdx   = '0;
    expFlags     = '0;
    $readmemh("dv/regAddrPathVectors.txt", vecMem);
    repeat (ResetCycles) @(posedge clk);
    // Reset leaves with the first vector, so no idle word enters execute
    for (int i = 0; i < NumVectors; i++) begin
      @(posedge clk);
      arstN <= 1'b1;
      driveVector(i);
    end
    @(posedge clk);
    checkValid <= 1'b0;
    #1;
    $display("Error count: %0d mismatches, %0d other errors", mismatchCount, otherCount);
    if (mismatchCount == 0 && otherCount == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule

// File: dv/regAddrPathChecker.sv
`timescale 1ns/1ps

module regAddrPathChecker
  import regBankPkg::*;
#(
  parameter int NumVectors = 1
) (
  input  logic       clk,
  input  logic       checkValid,
  input  int         vecIdx,
  input  logic [7:0] expCode,
  input  logic [7:0] expRa1Idx,
  input  logic [7:0] expRa2Idx,
  input  logic [7:0] expWa3WIdx,
  input  logic [7:0] expFlags,
  input  oneHotAddrT ra1D,
  input  oneHotAddrT ra2D,
  input  oneHotAddrT wa3W,
  // Bit 0 match1EM up to bit 5 match2DE
  input  logic [5:0] flags,
  output int         mismatchCount,
  output int         otherCount
);

  initial begin
    mismatchCount = 0;
    otherCount    = 0;
  end

  // ======================================================================
  // Helpers
  // ======================================================================

  function automatic string testName(input logic [7:0] code);
    case (code)
      8'h01:   return "bankedDecode";
      8'h02:   return "operandSelect";
      8'h03:   return "latencyFlush";
      8'h04:   return "stalls";
      8'h05:   return "forwarding";
      8'h06:   return "longMultiply";
      default: return "unknown";
    endcase
  endfunction

  // Physical index to select line with FF as no register
  function automatic oneHotAddrT idxToAddr(input logic [7:0] idx);
    if (idx == 8'hff) begin
      return '0;
    end
    return oneHotAddrT'(1) << idx[4:0];
  endfunction

  task automatic compareValue(input string sigName, input logic [31:0] expVal,
                              input logic [31:0] actVal);
    if (actVal !== expVal) begin
      mismatchCount++;
      $display("Mismatch in %s vector %0d %s: expected %h, actual %h",
               testName(expCode), vecIdx, sigName, expVal, actVal);
    end
  endtask

  // ======================================================================
  // Compare
  // ======================================================================

  // Sampled on the falling edge half a cycle after the inputs moved
  always @(negedge clk) begin
    if (checkValid) begin
      if (expCode >= 8'h01 && expCode <= 8'h06) begin
        compareValue("ra1D", idxToAddr(expRa1Idx), ra1D);
        compareValue("ra2D", idxToAddr(expRa2Idx), ra2D);
        compareValue("wa3W", idxToAddr(expWa3WIdx), wa3W);
        compareValue("match flags", {26'd0, expFlags[5:0]}, {26'd0, flags});
      end else begin
        // Line missing or unreadable
        otherCount++;
        $display("Vector file ended before vector %0d of %0d", vecIdx, NumVectors);
      end
    end
  end

endmodule

// File: verilog/regAddrPath.sv
`timescale 1ns/1ps

module regAddrPath
  import regBankPkg::*;
  import instrFieldPkg::*;
(
  input  logic                  clk,
  input  logic                  arstN,
  // Controller side
  input  logic [InstrWidth-1:0] instrD,
  input  logic [InstrWidth-1:0] instrE,
  input  logic                  multSelectD,
  input  logic [RegSrcBits-1:0] regSrcD,
  input  logic                  regShiftD,
  input  logic                  aluSrcD,
  input  logic                  writeMultLoE,
  input  procModeT              modeD,
  // Hazard unit controls
  input  logic                  stallE,
  input  logic                  stallM,
  input  logic                  flushM,
  input  logic                  stallW,
  input  logic                  flushW,
  // Register file addresses
  output oneHotAddrT            ra1D,
  output oneHotAddrT            ra2D,
  output oneHotAddrT            wa3W,
  // Hazard unit matches
  output logic                  match1EM,
  output logic                  match1EW,
  output logic                  match2EM,
  output logic                  match2EW,
  output logic                  match1DE,
  output logic                  match2DE
);

  // Destination in flight
  oneHotAddrT wa3E;
  oneHotAddrT wa3M;

  // ======================================================================
  // Decode-stage address bundle
  // ======================================================================

  regAddrIf decBus ();

  assign ra1D = decBus.ra1;
  assign ra2D = decBus.ra2;

  srcAddrDecode srcDec0 (
    .instrD      (instrD),
    .multSelectD (multSelectD),
    .regSrcD     (regSrcD),
    .regShiftD   (regShiftD),
    .aluSrcD     (aluSrcD),
    .modeD       (modeD),
    .dec         (decBus.source)
  );

  // Drives only the destination member of decBus
  destAddrPipe destPipe0 (
    .clk          (clk),
    .arstN        (arstN),
    .instrD       (instrD),
    .multSelectD  (multSelectD),
    .modeD        (modeD),
    .writeMultLoE (writeMultLoE),
    .instrE       (instrE),
    .stallE       (stallE),
    .stallM       (stallM),
    .flushM       (flushM),
    .stallW       (stallW),
    .flushW       (flushW),
    .wa3D         (decBus.wa3),
    .wa3E         (wa3E),
    .wa3M         (wa3M),
    .wa3W         (wa3W)
  );

  hazardMatch hazard0 (
    .clk      (clk),
    .arstN    (arstN),
    .stallE   (stallE),
    .dec      (decBus.sink),
    .wa3E     (wa3E),
    .wa3M     (wa3M),
    .wa3W     (wa3W),
    .match1EM (match1EM),
    .match1EW (match1EW),
    .match2EM (match2EM),
    .match2EW (match2EW),
    .match1DE (match1DE),
    .match2DE (match2DE)
  );

endmodule

// File: verilog/hazardMatch.sv
`timescale 1ns/1ps

module hazardMatch
  import regBankPkg::*;
(
  input  logic       clk,
  input  logic       arstN,
  input  logic       stallE,
  regAddrIf.sink     dec,
  input  oneHotAddrT wa3E,
  input  oneHotAddrT wa3M,
  input  oneHotAddrT wa3W,
  output logic       match1EM,
  output logic       match1EW,
  output logic       match2EM,
  output logic       match2EW,
  output logic       match1DE,
  output logic       match2DE
);

  // Read addresses of the instruction in execute
  oneHotAddrT ra1E;
  oneHotAddrT ra2E;
  logic       ra2UsedE;

  // Equal and not empty
  // An unused port reads zero and must never forward
  function automatic logic addrMatch(input oneHotAddrT readAddr,
                                     input oneHotAddrT writeAddr);
    return (readAddr == writeAddr) && (readAddr != '0);
  endfunction

  // ======================================================================
  // Execute stage copy of the read side
  // ======================================================================

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      ra1E     <= '0;
      ra2E     <= '0;
      ra2UsedE <= 1'b0;
    end else if (!stallE) begin
      ra1E     <= dec.ra1;
      ra2E     <= dec.ra2;
      ra2UsedE <= dec.ra2Used;
    end
  end

  // ======================================================================
  // Forwarding matches
  // ======================================================================

  // Execute operands against older results
  assign match1EM = addrMatch(ra1E, wa3M);
  assign match1EW = addrMatch(ra1E, wa3W);

  // Immediate in the Rm slot never forwards
  assign match2EM = addrMatch(ra2E, wa3M) & ra2UsedE;
  assign match2EW = addrMatch(ra2E, wa3W) & ra2UsedE;

  // ======================================================================
  // Load-use matches
  // ======================================================================

  // Decode operands against the instruction one ahead
  assign match1DE = addrMatch(dec.ra1, wa3E);
  assign match2DE = addrMatch(dec.ra2, wa3E) & dec.ra2Used;

endmodule

// File: verilog/destAddrPipe.sv
`timescale 1ns/1ps

module destAddrPipe
  import regBankPkg::*;
  import instrFieldPkg::*;
(
  input  logic                  clk,
  input  logic                  arstN,
  input  logic [InstrWidth-1:0] instrD,
  input  logic                  multSelectD,
  input  procModeT              modeD,
  input  logic                  writeMultLoE,
  input  logic [InstrWidth-1:0] instrE,
  input  logic                  stallE,
  input  logic                  stallM,
  input  logic                  flushM,
  input  logic                  stallW,
  input  logic                  flushW,
  output oneHotAddrT            wa3D,
  output oneHotAddrT            wa3E,
  output oneHotAddrT            wa3M,
  output oneHotAddrT            wa3W
);

  archRegT    destArchD;
  procModeT   modeE;
  oneHotAddrT rdLoE;
  oneHotAddrT wa3NextM;

  // ======================================================================
  // Decode
  // ======================================================================

  // Multiply writes Rn and all others Rd
  assign destArchD = multSelectD ? regField(instrD, RnLsb) : regField(instrD, RdLsb);
  assign wa3D      = toOneHot(destArchD, modeD);

  // ======================================================================
  // Execute
  // ======================================================================

  // Mode travels along for the RdLo decode
  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      wa3E  <= '0;
      modeE <= procModeT'(0);
    end else if (!stallE) begin
      wa3E  <= wa3D;
      modeE <= modeD;
    end
  end

  // Second write of a long multiply goes to RdLo
  assign rdLoE    = toOneHot(regField(instrE, RdLsb), modeE);
  assign wa3NextM = writeMultLoE ? rdLoE : wa3E;

  // ======================================================================
  // Memory
  // ======================================================================

  // Flush wins over stall
  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      wa3M <= '0;
    end else if (flushM) begin
      wa3M <= '0;
    end else if (!stallM) begin
      wa3M <= wa3NextM;
    end
  end

  // ======================================================================
  // Writeback
  // ======================================================================

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      wa3W <= '0;
    end else if (flushW) begin
      wa3W <= '0;
    end else if (!stallW) begin
      wa3W <= wa3M;
    end
  end

endmodule

// File: verilog/srcAddrDecode.sv
`timescale 1ns/1ps

module srcAddrDecode
  import regBankPkg::*;
  import instrFieldPkg::*;
(
  input  logic [InstrWidth-1:0] instrD,
  input  logic                  multSelectD,
  input  logic [RegSrcBits-1:0] regSrcD,
  input  logic                  regShiftD,
  input  logic                  aluSrcD,
  input  procModeT              modeD,
  regAddrIf.source              dec
);

  // ======================================================================
  // Field extraction
  // ======================================================================

  archRegT rnD;
  archRegT rsD;
  archRegT rmD;
  archRegT rdD;

  // Architectural numbers before banking
  archRegT ra1ArchD;
  archRegT ra2ArchD;

  // Port 2 picked Rm
  logic ra2IsRmD;

  assign rnD = regField(instrD, RnLsb);
  assign rdD = regField(instrD, RdLsb);
  assign rsD = regField(instrD, RsLsb);
  assign rmD = regField(instrD, RmLsb);

  // ======================================================================
  // Operand select
  // ======================================================================

  // Port 1
  // Multiply has top priority, then shift by register, then PC read
  always_comb begin
    if (multSelectD) begin
      ra1ArchD = rmD;
    end else if (regShiftD) begin
      // Shift amount comes from Rs
      ra1ArchD = rsD;
    end else if (regSrcD[RegSrcPcBit]) begin
      ra1ArchD = PcArchReg;
    end else begin
      ra1ArchD = rnD;
    end
  end

  // Port 2
  always_comb begin
    ra2IsRmD = 1'b0;
    if (multSelectD) begin
      // Multiplier operand
      ra2ArchD = rsD;
    end else if (regSrcD[RegSrcStoreBit]) begin
      // Store data
      ra2ArchD = rdD;
    end else begin
      ra2ArchD = rmD;
      ra2IsRmD = 1'b1;
    end
  end

  // ======================================================================
  // Banked one-hot addresses
  // ======================================================================

  // Mode at decode selects the bank
  assign dec.ra1 = toOneHot(ra1ArchD, modeD);
  assign dec.ra2 = toOneHot(ra2ArchD, modeD);

  // Rm slot may hold an immediate
  // Only a register operand counts for forwarding
  assign dec.ra2Used = ra2IsRmD & ~aluSrcD;

endmodule

// File: verilog/regAddrIf.sv
`timescale 1ns/1ps

// Decode-stage register addresses shared between the address blocks
interface regAddrIf
  import regBankPkg::*;
();

  // Read port addresses
  oneHotAddrT ra1;
  oneHotAddrT ra2;
  // Destination, driven by the destination pipe
  oneHotAddrT wa3;
  // Port 2 really reads a register, not an immediate
  logic       ra2Used;

  // Operand side of decode
  modport source (
    output ra1, ra2, ra2Used
  );

  // Hazard compare side
  modport sink (
    input ra1, ra2, wa3, ra2Used
  );

endinterface

// File: verilog/instrFieldPkg.sv
package instrFieldPkg;

  // ======================================================================
  // Instruction word layout seen by decode
  // ======================================================================

  localparam int InstrWidth = 32;

  // Register number fields
  localparam int RegFieldBits = 4;
  localparam int RnLsb        = 16;
  localparam int RdLsb        = 12;   // also RdLo of a long multiply
  localparam int RsLsb        = 8;
  localparam int RmLsb        = 0;

  typedef logic [RegFieldBits-1:0] archRegT;

  // ======================================================================
  // Register-select control from the decoder
  // ======================================================================

  localparam int RegSrcBits = 2;

  // Bit 0 forces the PC onto read port 1
  localparam int RegSrcPcBit = 0;
  // Bit 1 reads Rd on port 2 for stores
  localparam int RegSrcStoreBit = 1;

  // Pull one register field out of an instruction
  function automatic archRegT regField(input logic [InstrWidth-1:0] instr,
                                       input int                    lsb);
    return instr[lsb +: RegFieldBits];
  endfunction

endpackage

// File: verilog/regBankPkg.sv
package regBankPkg;

  // ======================================================================
  // Register file geometry
  // ======================================================================

  // Physical registers, one bit each in a one-hot address
  localparam int NumPhysRegs = 32;
  localparam int PhysIdxBits = $clog2(NumPhysRegs);

  // Architectural registers visible to an instruction
  localparam int NumArchRegs = 16;
  localparam int ArchIdxBits = $clog2(NumArchRegs);

  // R15 is never banked
  localparam logic [ArchIdxBits-1:0] PcArchReg = 4'd15;

  // Mode field of the status register
  typedef enum logic [4:0] {
    ModeUser  = 5'b10000,
    ModeFiq   = 5'b10001,
    ModeIrq   = 5'b10010,
    ModeSvc   = 5'b10011,
    ModeAbort = 5'b10111,
    ModeUndef = 5'b11011,
    ModeSys   = 5'b11111
  } procModeT;

  // All zeros means no register selected
  typedef logic [NumPhysRegs-1:0] oneHotAddrT;

  // Start of each private bank in the physical file
  // Slots 0..15 hold the user/system view and slot 31 stays empty
  localparam logic [PhysIdxBits-1:0] FiqBase = 5'd16;
  localparam logic [PhysIdxBits-1:0] IrqBase = 5'd23;
  localparam logic [PhysIdxBits-1:0] SvcBase = 5'd25;
  localparam logic [PhysIdxBits-1:0] AbtBase = 5'd27;
  localparam logic [PhysIdxBits-1:0] UndBase = 5'd29;

  // ======================================================================
  // Banked map
  // ======================================================================

  function automatic logic [PhysIdxBits-1:0] bankIndex(
      input logic [ArchIdxBits-1:0] archReg,
      input procModeT               mode);
    logic [PhysIdxBits-1:0] idx;
    // Shared slot unless a bank takes it
    idx = PhysIdxBits'(archReg);
    if (archReg != PcArchReg) begin
      if (mode == ModeFiq && archReg >= 4'd8) begin
        // fiq owns R8 to R14
        idx = FiqBase + PhysIdxBits'(archReg - 4'd8);
      end else if (archReg >= 4'd13) begin
        // SP and LR pair per exception mode
        case (mode)
          ModeIrq:   idx = IrqBase + PhysIdxBits'(archReg - 4'd13);
          ModeSvc:   idx = SvcBase + PhysIdxBits'(archReg - 4'd13);
          ModeAbort: idx = AbtBase + PhysIdxBits'(archReg - 4'd13);
          ModeUndef: idx = UndBase + PhysIdxBits'(archReg - 4'd13);
          default:   idx = PhysIdxBits'(archReg);
        endcase
      end
    end
    return idx;
  endfunction

  // Banked index turned into a register file select line
  function automatic oneHotAddrT toOneHot(input logic [ArchIdxBits-1:0] archReg,
                                          input procModeT               mode);
    oneHotAddrT addr;
    addr = '0;
    addr[bankIndex(archReg, mode)] = 1'b1;
    return addr;
  endfunction

endpackage
